// ==== rtl/exec_pkg.sv ====
package exec_pkg;

    // physical destination register tag
    localparam int TAG_W = 6;

    // operand and result width
    localparam int DATA_W = 32;

    // micro-op opcodes, codes 1 to 10 as the decoder emits them
    // 0 is an empty slot
    typedef enum logic [3:0] {
        op_nop  = 4'd0,
        op_add  = 4'd1,
        op_addi = 4'd2,
        op_lui  = 4'd3,
        op_ori  = 4'd4,
        op_xor  = 4'd5,
        op_srai = 4'd6,
        // memory ops, unit only forms the address
        op_lb   = 4'd7,
        op_lw   = 4'd8,
        op_sb   = 4'd9,
        op_sw   = 4'd10
    } alu_op_e;

    // function unit states
    typedef enum logic [1:0] {
        // free, waiting for start
        st_idle  = 2'd0,
        // serial arithmetic shift in progress
        st_shift = 2'd1,
        // result held until the merger takes it
        st_hold  = 2'd2
    } alu_state_e;

    // micro-op as handed from issue to a unit
    // 4 + 32 + 32 + 32 + 6 = 106 bits
    typedef struct packed {
        alu_op_e           op;
        logic [DATA_W-1:0] sr1;
        logic [DATA_W-1:0] sr2;
        logic [DATA_W-1:0] imm;
        logic [TAG_W-1:0]  tag;
    } issue_uop_t;

    // finished result, used by the units and the writeback bus
    // 6 + 32 = 38 bits
    typedef struct packed {
        logic [TAG_W-1:0]  tag;
        logic [DATA_W-1:0] data;
    } alu_result_t;

endpackage

// ==== rtl/int_alu.sv ====
`timescale 1ns/1ps

module int_alu import exec_pkg::*; #(
    // index of this unit within the cluster
    parameter int alu_no = 0
) (
    input  logic        clk,
    input  logic        rstn,
    input  logic        start,
    input  issue_uop_t  uop,
    output logic        busy,
    output logic        res_valid,
    output alu_result_t result,
    input  logic        res_ack
);

    alu_state_e        state;
    // remaining shift steps for srai
    logic [4:0]        shift_cnt;
    // tag and value of the result, also the shift register for srai
    alu_result_t       res_q;
    // one-cycle value for the incoming micro-op
    logic [DATA_W-1:0] calc;
    logic              take;
    logic              is_long_shift;

    // accept only when idle, dispatch never starts a busy unit
    assign take = start && (state == st_idle);

    // srai with a nonzero amount needs the shift state
    assign is_long_shift = (uop.op == op_srai) && (uop.imm[4:0] != 5'd0);

    // one-cycle result table
    always_comb begin
        case (uop.op)
            op_add:  calc = uop.sr1 + uop.sr2;
            op_addi: calc = uop.sr1 + uop.imm;
            // immediate already shifted by the decoder
            op_lui:  calc = uop.imm;
            op_ori:  calc = uop.sr1 | uop.imm;
            op_xor:  calc = uop.sr1 ^ uop.sr2;
            // starting value, shifted one bit per cycle afterwards
            op_srai: calc = uop.sr1;
            // effective address for loads and stores
            op_lb,
            op_lw,
            op_sb,
            op_sw:   calc = uop.sr1 + uop.imm;
            // nop and undefined codes give zero
            default: calc = '0;
        endcase
    end

    // control FSM
    always_ff @(posedge clk) begin
        if (!rstn) begin
            state     <= st_idle;
            shift_cnt <= 5'd0;
        end else begin
            case (state)
                st_idle: begin
                    if (take) begin
                        if (is_long_shift) begin
                            state     <= st_shift;
                            shift_cnt <= uop.imm[4:0];
                        end else begin
                            state <= st_hold;
                        end
                    end
                end
                st_shift: begin
                    shift_cnt <= shift_cnt - 5'd1;
                    // last step lands in hold
                    if (shift_cnt == 5'd1) begin
                        state <= st_hold;
                    end
                end
                st_hold: begin
                    if (res_ack) begin
                        state <= st_idle;
                    end
                end
                default: state <= st_idle;
            endcase
        end
    end

    // result payload
    always_ff @(posedge clk) begin
        if (take) begin
            res_q.tag  <= uop.tag;
            res_q.data <= calc;
        end else if (state == st_shift) begin
            // arithmetic step, sign bit replicated
            res_q.data <= {res_q.data[DATA_W-1], res_q.data[DATA_W-1:1]};
        end
    end

    // busy from start until the ack
    assign busy      = (state != st_idle);
    assign res_valid = (state == st_hold);
    assign result    = res_q;

endmodule

// ==== rtl/issue_dispatch.sv ====
`timescale 1ns/1ps

module issue_dispatch #(
    // number of function units fed
    parameter int num_alu = 2
) (
    input  logic               issue_valid,
    output logic               issue_ready,
    input  logic [num_alu-1:0] busy,
    output logic [num_alu-1:0] start
);

    // one-hot pick of the lowest free unit
    logic [num_alu-1:0] pick;
    // some unit can take a micro-op
    logic               any_free;

    // priority search, index 0 first
    always_comb begin
        pick     = '0;
        any_free = 1'b0;
        for (int i = 0; i < num_alu; i++) begin
            if (!busy[i] && !any_free) begin
                pick[i]  = 1'b1;
                any_free = 1'b1;
            end
        end
    end

    // ready whenever one unit is idle
    assign issue_ready = any_free;

    // start pulses only with the handshake
    // uop itself is a shared wire to every unit
    assign start = pick & {num_alu{issue_valid}};

endmodule

// ==== rtl/wb_merge.sv ====
`timescale 1ns/1ps

module wb_merge import exec_pkg::*; #(
    // number of units merged onto the bus
    parameter int num_alu = 2
) (
    input  logic               clk,
    input  logic               rstn,
    input  logic [num_alu-1:0] res_valid,
    input  alu_result_t        res_in [num_alu],
    output logic [num_alu-1:0] res_ack,
    output logic               wb_valid,
    input  logic               wb_ready,
    output alu_result_t        wb_result
);

    // pointer width, at least one bit
    localparam int IDX_W = (num_alu > 1) ? $clog2(num_alu) : 1;

    // unit that won the last grant
    logic [IDX_W-1:0] last_win;
    // current round-robin choice
    logic [IDX_W-1:0] grant_idx;
    logic             grant_any;
    // output register free or draining this cycle
    logic             can_load;
    logic             load;

    assign can_load = !wb_valid || wb_ready;

    // search starts just after the last winner
    always_comb begin
        int idx;
        grant_idx = '0;
        grant_any = 1'b0;
        for (int k = 1; k <= num_alu; k++) begin
            idx = (int'(last_win) + k) % num_alu;
            if (res_valid[idx] && !grant_any) begin
                grant_idx = IDX_W'(idx);
                grant_any = 1'b1;
            end
        end
    end

    assign load = grant_any && can_load;

    // ack only the winner and only when the register loads
    always_comb begin
        res_ack = '0;
        if (load) begin
            res_ack[grant_idx] = 1'b1;
        end
    end

    // valid flag and fairness pointer
    always_ff @(posedge clk) begin
        if (!rstn) begin
            wb_valid <= 1'b0;
            // unit 0 goes first after reset
            last_win <= IDX_W'(num_alu - 1);
        end else begin
            if (load) begin
                wb_valid <= 1'b1;
                last_win <= grant_idx;
            end else if (wb_ready) begin
                // consumed with nothing to replace it
                wb_valid <= 1'b0;
            end
        end
    end

    // output payload
    always_ff @(posedge clk) begin
        if (load) begin
            wb_result <= res_in[grant_idx];
        end
    end

endmodule

// ==== rtl/exec_cluster.sv ====
`timescale 1ns/1ps

module exec_cluster import exec_pkg::*; (
    input  logic        clk,
    input  logic        rstn,
    input  logic        issue_valid,
    output logic        issue_ready,
    input  issue_uop_t  issue_uop,
    output logic        wb_valid,
    input  logic        wb_ready,
    output alu_result_t wb_result
);

    // two units side by side
    localparam int num_alu = 2;

    logic [num_alu-1:0] alu_busy;
    logic [num_alu-1:0] alu_start;
    logic [num_alu-1:0] alu_res_valid;
    logic [num_alu-1:0] alu_res_ack;
    alu_result_t        alu_result [num_alu];

    // steering to the lowest free unit
    issue_dispatch #(
        .num_alu     (num_alu)
    ) i_issue_dispatch (
        .issue_valid (issue_valid),
        .issue_ready (issue_ready),
        .busy        (alu_busy),
        .start       (alu_start)
    );

    // function units, uop shared by all
    for (genvar g = 0; g < num_alu; g++) begin : g_alu
        int_alu #(
            .alu_no    (g)
        ) i_int_alu (
            .clk       (clk),
            .rstn      (rstn),
            .start     (alu_start[g]),
            .uop       (issue_uop),
            .busy      (alu_busy[g]),
            .res_valid (alu_res_valid[g]),
            .result    (alu_result[g]),
            .res_ack   (alu_res_ack[g])
        );
    end

    // results onto the single writeback bus
    wb_merge #(
        .num_alu   (num_alu)
    ) i_wb_merge (
        .clk       (clk),
        .rstn      (rstn),
        .res_valid (alu_res_valid),
        .res_in    (alu_result),
        .res_ack   (alu_res_ack),
        .wb_valid  (wb_valid),
        .wb_ready  (wb_ready),
        .wb_result (wb_result)
    );

endmodule

// ==== testbench/exec_assertions.sv ====
`timescale 1ns/1ps

module exec_assertions import exec_pkg::*; #(
    // index of the unit this copy sits in
    parameter int alu_no = 0
) (
    input logic        clk,
    input logic        rstn,
    input logic        start,
    input logic        busy,
    input logic        res_valid,
    input alu_result_t result,
    input logic        res_ack
);

    // failures seen by this copy, summed by the testbench
    int fail_cnt;

    initial begin
        fail_cnt = 0;
    end

    // offered result stays put until the merger acks it
    hold_stable: assert property (@(posedge clk) disable iff (!rstn)
        res_valid && !res_ack |=> res_valid && $stable(result))
        else begin
            $error("unit %0d result dropped or changed before ack", alu_no);
            fail_cnt++;
        end

    // a pending result keeps the unit busy
    busy_covers_valid: assert property (@(posedge clk) disable iff (!rstn)
        res_valid |-> busy)
        else begin
            $error("unit %0d res_valid high while not busy", alu_no);
            fail_cnt++;
        end

    // dispatch only starts a free unit
    no_start_busy: assert property (@(posedge clk) disable iff (!rstn)
        start |-> !busy)
        else begin
            $error("unit %0d started while busy", alu_no);
            fail_cnt++;
        end

endmodule

// ==== testbench/exec_checker.sv ====
`timescale 1ns/1ps

module exec_checker import exec_pkg::*; (
    input  logic              clk,
    input  logic              rstn,
    input  logic              issue_valid,
    input  logic              issue_ready,
    input  issue_uop_t        issue_uop,
    input  logic [DATA_W-1:0] exp_data,
    input  logic              wb_valid,
    input  logic              wb_ready,
    input  alu_result_t       wb_result,
    output int                errors,
    output int                done_cnt
);

    localparam int NUM_TAGS = 2 ** TAG_W;

    // expectation per destination tag, filled at issue
    logic [DATA_W-1:0] exp_by_tag  [NUM_TAGS];
    alu_op_e           op_by_tag   [NUM_TAGS];
    int                test_by_tag [NUM_TAGS];
    bit                pending     [NUM_TAGS];
    int                issued;
    // first cycle out of reset already looked at
    bit                reset_checked;

    initial begin
        errors        = 0;
        done_cnt      = 0;
        issued        = 0;
        reset_checked = 1'b0;
        for (int t = 0; t < NUM_TAGS; t++) begin
            pending[t] = 1'b0;
        end
    end

    // everything sampled on the rising edge, inputs move 1 ns later
    always @(posedge clk) begin
        // idle outputs right after reset
        if (rstn && !reset_checked) begin
            reset_checked = 1'b1;
            if (wb_valid !== 1'b0) begin
                $display("mismatch at %0d ns: wb_valid got %b expected 0", $time, wb_valid);
                errors++;
            end
            if (issue_ready !== 1'b1) begin
                $display("mismatch at %0d ns: issue_ready got %b expected 1",
                         $time, issue_ready);
                errors++;
            end
        end

        // issue handshake records what the tag should return
        if (rstn && issue_valid && issue_ready) begin
            if (pending[issue_uop.tag]) begin
                $display("error at %0d ns: tag %0d issued again while still outstanding",
                         $time, issue_uop.tag);
                errors++;
            end
            pending[issue_uop.tag]     = 1'b1;
            exp_by_tag[issue_uop.tag]  = exp_data;
            op_by_tag[issue_uop.tag]   = issue_uop.op;
            test_by_tag[issue_uop.tag] = issued;
            issued++;
        end

        // writeback handshake, any order allowed
        if (rstn && wb_valid && wb_ready) begin
            if (!pending[wb_result.tag]) begin
                $display("error at %0d ns: writeback of tag %0d which is not outstanding",
                         $time, wb_result.tag);
                errors++;
            end else begin
                pending[wb_result.tag] = 1'b0;
                done_cnt++;
                if (wb_result.data !== exp_by_tag[wb_result.tag]) begin
                    $display("mismatch at %0d ns: wb_result.data tag %0d got %h expected %h",
                             $time, wb_result.tag, wb_result.data,
                             exp_by_tag[wb_result.tag]);
                    errors++;
                    $display("test %0d tag %0d %s failed", test_by_tag[wb_result.tag],
                             wb_result.tag, op_by_tag[wb_result.tag].name());
                end else begin
                    $display("test %0d tag %0d %s result %h ok", test_by_tag[wb_result.tag],
                             wb_result.tag, op_by_tag[wb_result.tag].name(), wb_result.data);
                end
            end
        end
    end

endmodule

// ==== testbench/tb_exec_cluster.sv ====
`timescale 1ns/1ps

module tb_exec_cluster import exec_pkg::*; ();

    localparam int RESET_CYCLES    = 8;
    localparam int MAX_TESTS       = 64;
    // opcode, sr1, sr2, imm, tag, expected
    localparam int WORDS           = 6;
    // longest srai plus slack for back-pressure
    localparam int CYCLES_PER_TEST = 32 + 8;

    logic              clk;
    logic              rstn;
    logic              issue_valid;
    logic              issue_ready;
    issue_uop_t        issue_uop;
    logic [DATA_W-1:0] exp_data;
    logic              wb_valid;
    logic              wb_ready;
    alu_result_t       wb_result;

    logic [31:0]       tdata [MAX_TESTS*WORDS];
    int                num_tests;
    int                cycle_limit;
    int                cycles;
    int                seed;
    int                errors;
    int                done_cnt;
    int                assert_fails;

    exec_cluster i_exec_cluster (
        .clk         (clk),
        .rstn        (rstn),
        .issue_valid (issue_valid),
        .issue_ready (issue_ready),
        .issue_uop   (issue_uop),
        .wb_valid    (wb_valid),
        .wb_ready    (wb_ready),
        .wb_result   (wb_result)
    );

    // scoreboard beside the DUT
    exec_checker i_exec_checker (
        .clk         (clk),
        .rstn        (rstn),
        .issue_valid (issue_valid),
        .issue_ready (issue_ready),
        .issue_uop   (issue_uop),
        .exp_data    (exp_data),
        .wb_valid    (wb_valid),
        .wb_ready    (wb_ready),
        .wb_result   (wb_result),
        .errors      (errors),
        .done_cnt    (done_cnt)
    );

    // one assertion copy per function unit
    bind int_alu exec_assertions #(
        .alu_no    (alu_no)
    ) i_exec_assertions (
        .clk       (clk),
        .rstn      (rstn),
        .start     (start),
        .busy      (busy),
        .res_valid (res_valid),
        .result    (result),
        .res_ack   (res_ack)
    );

    initial begin
        clk = 1'b0;
    end

    always #10 clk = ~clk;

    // random back-pressure, ready about three cycles in four
    always @(posedge clk) begin
        #1;
        wb_ready = ($random(seed) % 4) != 0;
    end

    // sentinel opcode marks the end of the loaded entries
    task automatic load_tests();
        for (int i = 0; i < MAX_TESTS * WORDS; i++) begin
            tdata[i] = '1;
        end
        $readmemh("testbench/exec_testdata.txt", tdata);
        num_tests = 0;
        while (num_tests < MAX_TESTS && tdata[num_tests*WORDS] != 32'hffff_ffff) begin
            num_tests++;
        end
    endtask

    // called 1 ns after an edge, returns 1 ns after the handshake edge
    task automatic issue_one(input int n);
        int base;
        base           = n * WORDS;
        issue_valid    = 1'b1;
        issue_uop.op   = alu_op_e'(tdata[base][3:0]);
        issue_uop.sr1  = tdata[base+1];
        issue_uop.sr2  = tdata[base+2];
        issue_uop.imm  = tdata[base+3];
        issue_uop.tag  = tdata[base+4][TAG_W-1:0];
        exp_data       = tdata[base+5];
        do begin
            @(posedge clk);
        end while (!issue_ready);
        #1;
    endtask

    initial begin
        issue_valid = 1'b0;
        issue_uop   = '0;
        exp_data    = '0;
        wb_ready    = 1'b0;
        rstn        = 1'b0;
        seed        = 63835;
        cycle_limit = 0;
        load_tests();
        cycle_limit = num_tests * CYCLES_PER_TEST + RESET_CYCLES;
        repeat (RESET_CYCLES) @(posedge clk);
        #1;
        rstn = 1'b1;
        for (int n = 0; n < num_tests; n++) begin
            issue_one(n);
        end
        issue_valid = 1'b0;
        while (done_cnt < num_tests) begin
            @(posedge clk);
        end
        // room for a stray repeated writeback to show up
        repeat (4) @(posedge clk);
        assert_fails = i_exec_cluster.g_alu[0].i_int_alu.i_exec_assertions.fail_cnt
                     + i_exec_cluster.g_alu[1].i_int_alu.i_exec_assertions.fail_cnt;
        $display("tests %0d of %0d done, errors %0d, assertion failures %0d",
                 done_cnt, num_tests, errors, assert_fails);
        if (errors == 0 && assert_fails == 0 && num_tests > 0 && done_cnt == num_tests) begin
            $display("TB PASSED");
        end else begin
            $display("TB FAILED");
        end
        $finish;
    end

    // run limit from the number of loaded entries
    initial begin
        wait (cycle_limit > 0);
        cycles = 0;
        while (cycles < cycle_limit) begin
            @(posedge clk);
            cycles++;
        end
        $display("timeout after %0d cycles with %0d of %0d tests finished",
                 cycles, done_cnt, num_tests);
        $display("TB FAILED");
        $finish;
    end

endmodule

// ==== testbench/exec_testdata.txt ====
// one micro-op per line
// opcode sr1 sr2 imm tag expected in hex
1 00000005 00000007 00000000 01 0000000c
1 ffffffff 00000001 00000000 02 00000000
2 00001000 00000000 fffffff0 03 00000ff0
3 0000abcd 00000000 12345000 04 12345000
4 f0f00000 00000000 0000ff0f 05 f0f0ff0f
5 aaaa5555 ffff0000 00000000 06 55555555
6 80000000 00000000 0000001f 07 ffffffff
1 00000010 00000020 00000000 08 00000030
6 12345678 00000000 00000004 09 01234567
6 f0000000 00000000 00000000 0a f0000000
6 c0000000 00000000 00000008 0b ffc00000
6 fffffffe 00000000 00000021 0c ffffffff
7 00002000 00000000 00000004 0d 00002004
8 00004000 00000000 fffffffc 0e 00003ffc
9 10000000 deadbeef 00000010 0f 10000010
a 7ffffff0 00000000 00000020 10 80000010
5 12345678 12345678 00000000 11 00000000
4 00000000 00000000 ffffffff 12 ffffffff
6 7fffffff 00000000 0000001e 13 00000001
2 7fffffff 00000000 00000001 14 80000000
0 00001111 00002222 00003333 15 00000000
8 00000100 00000000 00000008 16 00000108
6 80000001 00000000 00000005 17 fc000000

// ==== build.f ====
rtl/exec_pkg.sv
rtl/int_alu.sv
rtl/issue_dispatch.sv
rtl/wb_merge.sv
rtl/exec_cluster.sv
testbench/exec_assertions.sv
testbench/exec_checker.sv
testbench/tb_exec_cluster.sv
